/* iob_wb_subsys.f */
verilog/iob_wb_pkg.sv
verilog/iob_iob2wishbone.sv
verilog/iob_wb_ram.sv
verilog/iob_wb_regs.sv
verilog/iob_wb_decoder.sv
verilog/iob_wb_subsys.sv
testbench/iob_wb_subsys_tb.sv

/* Makefile */
# Verilator build and run for the IOb to Wishbone subsystem.

VERILATOR ?= verilator
TB_TOP    ?= iob_wb_subsys_tb
RTL_TOP   ?= iob_wb_subsys
FILELIST  ?= iob_wb_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

PASS_MSG := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/iob_wb_subsys_tb.sv */
`timescale 1ns/1ps

module iob_wb_subsys_tb
   import iob_wb_pkg::*;
();

   localparam int CLK_PERIOD    = 8;
   localparam int RESET_CYCLES  = 10;
   localparam int N_RANDOM      = 200;
   localparam int N_TRANS_MAX   = 300;
   localparam int CYC_PER_TRANS = 3;
   localparam int WATCHDOG_NS   = N_TRANS_MAX * CYC_PER_TRANS * CLK_PERIOD + 12800;
   localparam int RSP_TIMEOUT   = 16;
   localparam int RAM_WORDS     = 2**RAM_AW;
   localparam logic [ADDR_W-1:0] REGS_BASE = ADDR_W'(1) << REGS_SEL_BIT;

   logic              clk;
   logic              rst_n;
   logic              avalid;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              rvalid;
   logic [DATA_W-1:0] rdata;
   logic              ready;

   logic              acc_rd;
   logic [DATA_W-1:0] exp_next;
   logic [DATA_W-1:0] exp_lat;

   // Reference model.
   logic [DATA_W-1:0] ram_model [RAM_WORDS];
   logic              ram_written [RAM_WORDS];
   logic [DATA_W-1:0] scratch_model;
   logic [DATA_W-1:0] count_model;

   int     err_cnt;
   int     err_at_start;
   int     tests_run;
   int     tests_failed;
   int     reads_done;
   string  cur_name;
   integer seed;

   iob_wb_subsys u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_avalid_i(avalid),
      .iob_addr_i  (addr),
      .iob_wdata_i (wdata),
      .iob_wstrb_i (wstrb),
      .iob_rvalid_o(rvalid),
      .iob_rdata_o (rdata),
      .iob_ready_o (ready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   assign acc_rd = avalid & ready & ~(|wstrb);

   always @(posedge clk) begin
      if (acc_rd) exp_lat <= exp_next;  // Expected word at acceptance.
   end

   a_read_data: assert property (
      @(posedge clk) disable iff (!rst_n)
      $past(acc_rd, 2) |-> (rvalid && rdata == exp_lat)
   ) else begin
      err_cnt++;
      $display("mismatch at %0t: rdata %08h rvalid %0b, expected %08h",
               $time, $sampled(rdata), $sampled(rvalid), $sampled(exp_lat));
   end

   // No rvalid without a read two cycles back.
   a_rvalid_origin: assert property (
      @(posedge clk) disable iff (!rst_n)
      rvalid |-> $past(acc_rd, 2)
   ) else begin
      err_cnt++;
      $display("mismatch at %0t: rvalid without a read accepted two cycles earlier", $time);
   end

   a_reset_state: assert property (
      @(posedge clk) $rose(rst_n) |-> (ready && !rvalid)
   ) else begin
      err_cnt++;
      $display("mismatch at %0t: ready %0b rvalid %0b after reset, expected 1 and 0",
               $time, $sampled(ready), $sampled(rvalid));
   end

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] ram_addr(input int idx);
      return ADDR_W'(idx) << 2;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input reg_idx_e idx);
      return REGS_BASE | (ADDR_W'(idx) << 2);
   endfunction

   function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] a);
      if (!a[REGS_SEL_BIT]) return ram_model[a[RAM_AW+1:2]];
      case (reg_idx_e'(a[3:2]))
         REG_SCRATCH: return scratch_model;
         REG_COUNT:   return count_model;
         REG_ID:      return REGS_ID;
         default:     return '0;
      endcase
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                              input logic [STRB_W-1:0] s);
      int i;
      i = int'(a[RAM_AW+1:2]);
      if (a[REGS_SEL_BIT]) begin
         if (reg_idx_e'(a[3:2]) == REG_SCRATCH) begin
            scratch_model = merge_bytes(scratch_model, d, s);
            count_model   = count_model + 1;
         end
      end else begin
         ram_model[i]   = merge_bytes(ram_model[i], d, s);
         ram_written[i] = 1'b1;
      end
   endtask

   // Called on a falling edge; returns on the falling edge where ready is high.
   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && n < RSP_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!ready) begin
         err_cnt++;
         $display("The DUT did not raise ready within %0d cycles.", RSP_TIMEOUT);
      end
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [STRB_W-1:0] s);
      wait_ready();
      model_write(a, d, s);
      avalid = 1'b1;
      addr   = a;
      wdata  = d;
      wstrb  = s;
      @(negedge clk);
      avalid = 1'b0;
      wstrb  = '0;
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] a);
      int n;
      wait_ready();
      exp_next = model_read(a);
      avalid   = 1'b1;
      addr     = a;
      wdata    = '0;
      wstrb    = '0;
      @(negedge clk);
      avalid = 1'b0;
      n = 0;
      while (!rvalid && n < RSP_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!rvalid) begin
         err_cnt++;
         $display("The read of address %08h never got rvalid.", a);
      end
      reads_done++;
   endtask

   task automatic start_test(input string name);
      cur_name     = name;
      err_at_start = err_cnt;
   endtask

   task automatic end_test();
      repeat (3) @(negedge clk);  // Let the last read check fire.
      tests_run++;
      if (err_cnt != err_at_start) begin
         tests_failed++;
         $display("test %0d %s: FAIL", tests_run, cur_name);
      end else begin
         $display("test %0d %s: PASS", tests_run, cur_name);
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("The watchdog expired before the tests finished.");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [31:0]       r;
      logic [ADDR_W-1:0] a;
      logic [STRB_W-1:0] s;
      int                idx;
      rst_n  = 1'b0;
      avalid = 1'b0;
      addr   = '0;
      wdata  = '0;
      wstrb  = '0;
      seed   = 29665;
      err_cnt = 0;
      tests_run = 0;
      tests_failed = 0;
      reads_done = 0;
      scratch_model = '0;
      count_model   = '0;
      for (int i = 0; i < RAM_WORDS; i++) ram_written[i] = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;

      start_test("reset state");
      repeat (4) @(negedge clk);
      end_test();

      start_test("ram full words");
      for (int i = 0; i < 8; i++) bus_write(ram_addr(i * 13), $random(seed), 4'hF);
      bus_write(ram_addr(0), 32'h0BAD_F00D, 4'hF);  // Overwrite.
      for (int i = 0; i < 8; i++) bus_read(ram_addr(i * 13));
      end_test();

      start_test("ram byte lanes");
      bus_write(ram_addr(40), 32'h1122_3344, 4'hF);
      bus_write(ram_addr(40), 32'hAABB_CCDD, 4'b0001);
      bus_read(ram_addr(40));
      bus_write(ram_addr(40), 32'h5566_7788, 4'b0110);
      bus_read(ram_addr(40));
      bus_write(ram_addr(40), 32'h99EE_FF00, 4'b1000);
      bus_read(ram_addr(40));
      end_test();

      start_test("register block");
      bus_write(reg_addr(REG_SCRATCH), 32'h0123_4567, 4'hF);
      bus_write(reg_addr(REG_SCRATCH), 32'hDEAD_BEEF, 4'b1010);
      bus_read(reg_addr(REG_SCRATCH));
      bus_read(reg_addr(REG_ID));
      bus_write(reg_addr(REG_ID), 32'h0, 4'hF);
      bus_read(reg_addr(REG_ID));
      bus_read(reg_addr(REG_RSVD));
      end_test();

      start_test("scratch write count");
      for (int i = 0; i < 6; i++) begin
         bus_write(reg_addr(REG_SCRATCH), $random(seed), 4'b0011);
         bus_write(ram_addr(100 + i), $random(seed), 4'hF);
      end
      bus_read(reg_addr(REG_COUNT));
      end_test();

      start_test("random traffic");
      for (int n = 0; n < N_RANDOM; n++) begin
         r = $random(seed);
         s = (r[7:4] == 4'h0) ? 4'hF : r[7:4];
         if (r[0]) begin
            a = reg_addr(reg_idx_e'(r[3:2]));
            if (r[1]) bus_write(a, $random(seed), s);
            else bus_read(a);
         end else begin
            idx = int'(r[12:8]);
            a   = ram_addr(idx);
            if (!ram_written[idx]) bus_write(a, $random(seed), 4'hF);  // Defined first.
            else if (r[1]) bus_write(a, $random(seed), s);
            else bus_read(a);
         end
      end
      end_test();

      $display("tests run %0d, tests failed %0d, reads %0d, errors %0d",
               tests_run, tests_failed, reads_done, err_cnt);
      if (err_cnt == 0 && tests_failed == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* verilog/iob_wb_subsys.sv */
`timescale 1ns/1ps

module iob_wb_subsys
   import iob_wb_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o
);

   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   wb_req_t ram_req;
   wb_rsp_t ram_rsp;
   wb_req_t regs_req;
   wb_rsp_t regs_rsp;

   iob_iob2wishbone u_bridge (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .iob_ready_o (iob_ready_o),
      .wb_req_o    (wb_req),
      .wb_rsp_i    (wb_rsp)
   );

   iob_wb_decoder u_decoder (
      .wb_req_i  (wb_req),
      .ram_req_o (ram_req),
      .ram_rsp_i (ram_rsp),
      .regs_req_o(regs_req),
      .regs_rsp_i(regs_rsp),
      .wb_rsp_o  (wb_rsp)
   );

   iob_wb_ram u_ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wb_req_i(ram_req),
      .wb_rsp_o(ram_rsp)
   );

   iob_wb_regs u_regs (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wb_req_i(regs_req),
      .wb_rsp_o(regs_rsp)
   );

endmodule

/* verilog/iob_wb_decoder.sv */
`timescale 1ns/1ps

module iob_wb_decoder
   import iob_wb_pkg::*;
(
   input  wb_req_t wb_req_i,

   // RAM port.
   output wb_req_t ram_req_o,
   input  wb_rsp_t ram_rsp_i,

   // Register block port.
   output wb_req_t regs_req_o,
   input  wb_rsp_t regs_rsp_i,

   output wb_rsp_t wb_rsp_o
);

   logic regs_hit;

   assign regs_hit = wb_req_i.addr[REGS_SEL_BIT];

   // Same request to both, strobe only to the addressed one.
   always_comb begin
      ram_req_o     = wb_req_i;
      ram_req_o.stb = wb_req_i.stb & ~regs_hit;
      ram_req_o.cyc = wb_req_i.cyc & ~regs_hit;

      regs_req_o     = wb_req_i;
      regs_req_o.stb = wb_req_i.stb & regs_hit;
      regs_req_o.cyc = wb_req_i.cyc & regs_hit;
   end

   // Address is held by the master while ack is pending.
   always_comb begin
      wb_rsp_o.ack  = ram_rsp_i.ack | regs_rsp_i.ack;
      wb_rsp_o.data = regs_hit ? regs_rsp_i.data : ram_rsp_i.data;
   end

   // Only one slave may answer at a time.
   always_comb begin
      a_single_ack: assert (!(ram_rsp_i.ack && regs_rsp_i.ack))
         else $error("RAM and register block acknowledged together");
   end

endmodule

/* verilog/iob_wb_regs.sv */
`timescale 1ns/1ps

module iob_wb_regs
   import iob_wb_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o
);

   reg_idx_e          idx;
   logic              access;
   logic              scratch_wr;
   logic              ack_r;
   logic [DATA_W-1:0] scratch_q;
   logic [DATA_W-1:0] count_q;
   logic [DATA_W-1:0] rd_word;
   logic [DATA_W-1:0] rdata_r;

   assign idx    = reg_idx_e'(wb_req_i.addr[3:2]);
   assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_r;

   // Other indices are read-only.
   assign scratch_wr = access & wb_req_i.we & (idx == REG_SCRATCH);

   always_comb begin
      case (idx)
         REG_SCRATCH: rd_word = scratch_q;
         REG_COUNT:   rd_word = count_q;
         REG_ID:      rd_word = REGS_ID;
         default:     rd_word = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         scratch_q <= '0;
         count_q   <= '0;
         ack_r     <= 1'b0;
      end else begin
         ack_r <= access;
         if (scratch_wr) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (wb_req_i.sel[b]) begin
                  scratch_q[8*b +: 8] <= wb_req_i.data[8*b +: 8];
               end
            end
            count_q <= count_q + 1'b1;  // One per acknowledged write.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         rdata_r <= rd_word;
      end
   end

   assign wb_rsp_o.data = rdata_r;
   assign wb_rsp_o.ack  = ack_r;

endmodule

/* verilog/iob_wb_ram.sv */
`timescale 1ns/1ps

module iob_wb_ram
   import iob_wb_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  wb_req_t wb_req_i,
   output wb_rsp_t wb_rsp_o
);

   logic [DATA_W-1:0] mem [2**RAM_AW];

   logic [RAM_AW-1:0] idx;
   logic              access;
   logic              ack_r;
   logic [DATA_W-1:0] rdata_r;

   assign idx = wb_req_i.addr[RAM_AW+1:2];  // Word index.

   // First cycle of a strobe only.
   assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_r;

   always_ff @(posedge clk_i) begin
      if (access) begin
         if (wb_req_i.we) begin
            for (int b = 0; b < STRB_W; b++) begin
               if (wb_req_i.sel[b]) begin
                  mem[idx][8*b +: 8] <= wb_req_i.data[8*b +: 8];
               end
            end
         end
         rdata_r <= mem[idx];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_r <= 1'b0;
      end else begin
         ack_r <= access;
      end
   end

   assign wb_rsp_o.data = rdata_r;
   assign wb_rsp_o.ack  = ack_r;

   // Ack answers a strobe the master still holds.
   a_ack_on_stb: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      ack_r |-> (wb_req_i.cyc && wb_req_i.stb)
   ) else $error("RAM ack without a held strobe");

endmodule

/* verilog/iob_iob2wishbone.sv */
`timescale 1ns/1ps

module iob_iob2wishbone
   import iob_wb_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,

   // IOb slave side.
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o,

   // Wishbone master side.
   output wb_req_t           wb_req_o,
   input  wb_rsp_t           wb_rsp_i
);

   logic              we;
   logic [STRB_W-1:0] sel;

   logic              avalid_r;
   logic [ADDR_W-1:0] addr_r;
   logic [DATA_W-1:0] wdata_r;
   logic [STRB_W-1:0] sel_r;
   logic              we_r;
   logic              ack_r;
   logic [DATA_W-1:0] rdata_r;

   assign we = |iob_wstrb_i;  // All-zero strobe is a read.

   // Reads enable READ_BYTES lanes from the addressed byte.
   assign sel = we ? iob_wstrb_i : STRB_W'({READ_BYTES{1'b1}}) << iob_addr_i[1:0];

   // Live request in the accept cycle, held copy while waiting for ack.
   always_comb begin
      wb_req_o.addr = iob_avalid_i ? iob_addr_i : addr_r;
      wb_req_o.data = iob_avalid_i ? iob_wdata_i : wdata_r;
      wb_req_o.sel  = iob_avalid_i ? sel : sel_r;
      wb_req_o.we   = iob_avalid_i ? we : we_r;
      wb_req_o.stb  = iob_avalid_i | avalid_r;
      wb_req_o.cyc  = iob_avalid_i | avalid_r;
   end

   // Pending flag cleared by the slave ack.
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         avalid_r <= 1'b0;
         ack_r    <= 1'b0;
      end else begin
         if (iob_avalid_i || wb_rsp_i.ack) begin
            avalid_r <= iob_avalid_i;
         end
         ack_r <= wb_rsp_i.ack;
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_avalid_i) begin
         addr_r  <= iob_addr_i;
         wdata_r <= iob_wdata_i;
         sel_r   <= sel;
         we_r    <= we;
      end
      rdata_r <= wb_rsp_i.data;
   end

   assign iob_rvalid_o = ack_r & ~we_r;
   assign iob_rdata_o  = rdata_r;
   assign iob_ready_o  = ~avalid_r | ack_r;

   // Master may only issue while ready.
   a_avalid_when_ready: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(iob_avalid_i && !iob_ready_o)
   ) else $error("avalid raised while ready is low");

   // Classic cycle holds stb until the slave acknowledges it a cycle later.
   a_stb_until_ack: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (wb_req_o.stb && !wb_rsp_i.ack) |=> (wb_req_o.stb && wb_rsp_i.ack)
   ) else $error("stb not acknowledged in the next cycle");

endmodule

/* verilog/iob_wb_pkg.sv */
package iob_wb_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Number of byte lanes enabled on a read.
   localparam int READ_BYTES = 4;

   // RAM holds 2**RAM_AW words.
   localparam int RAM_AW = 8;

   // Address bit that selects the register block over the RAM.
   localparam int REGS_SEL_BIT = 12;

   localparam logic [DATA_W-1:0] REGS_ID = 32'hA5C3_0102;

   // Register index, taken from address bits 3:2.
   typedef enum logic [1:0] {
      REG_SCRATCH = 2'd0,  // Read/write, byte strobes.
      REG_COUNT   = 2'd1,  // Scratch write count.
      REG_ID      = 2'd2,
      REG_RSVD    = 2'd3   // Reads zero.
   } reg_idx_e;

   // Master side of a Wishbone classic cycle.
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   // Slave side.
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              ack;
   } wb_rsp_t;

endpackage
